//--- hw/tx_pkg.sv
//----------------------------------------
// Shared definitions of the transmit path
// Buffer geometry, data types, frame limits
// Interrupt hold-off, sender states
//----------------------------------------
package tx_pkg;

    //----------------------------------------
    // Frame buffer geometry
    //----------------------------------------
    localparam int IBUF_AW = 9;                     // 512 quadwords

    typedef logic [IBUF_AW:0]   ptr_t;              // MSB is the wrap bit
    typedef logic [IBUF_AW-1:0] addr_t;             // Buffer word address
    typedef logic [63:0]        qword_t;            // One bus beat
    typedef logic [7:0]         bmask_t;            // Byte valid, LSB first
    typedef logic [15:0]        flen_t;             // Frame length in bytes
    typedef logic [$clog2($bits(bmask_t)):0] rem_t; // Bytes in last beat, 1 to 8

    //----------------------------------------
    // Frame limits
    //----------------------------------------
    localparam int MIN_FRAME_BYTES = 60;
    localparam int MAX_FRAME_BYTES = 1518;
    localparam int MAX_FRAME_QW    = (MAX_FRAME_BYTES + 7) / 8;  // 190
    localparam int FRAME_SLOT_QW   = MAX_FRAME_QW + 1;           // Plus header word

    // Minimum interrupt spacing, pcie_clk cycles
    localparam int IRQ_HOLDOFF = 64;
    typedef logic [$clog2(IRQ_HOLDOFF):0] hold_t;

    typedef enum logic [2:0] {
        ST_IDLE,      // Wait for a committed frame
        ST_HEADER,    // Header word on rd_data
        ST_START,     // Request the MAC
        ST_STREAM,    // One quadword per cycle
        ST_COMMIT     // Release the frame
    } mac_state_e;

endpackage

//--- hw/tx_ibuf.sv
//----------------------------------------
// Frame buffer, simple dual port, 64 bit
// Write on pcie_clk, registered read on mac_clk
//----------------------------------------
`timescale 1ns/1ns

module tx_ibuf (
    input  logic           pcie_clk,   // Write clock
    input  logic           wr_en,
    input  tx_pkg::addr_t  wr_addr,
    input  tx_pkg::qword_t wr_data,
    input  logic           mac_clk,    // Read clock
    input  tx_pkg::addr_t  rd_addr,
    output tx_pkg::qword_t rd_data     // One mac_clk after rd_addr
);

    tx_pkg::qword_t mem [2**tx_pkg::IBUF_AW];   // Headers and frame data

    // Host side write port
    always_ff @(posedge pcie_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // MAC side read, output register
    always_ff @(posedge mac_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hw/ptr_sync.sv
//----------------------------------------
// Gray code pointer synchronizer
// Launch flop in source, two flops in destination
//----------------------------------------
`timescale 1ns/1ns

module ptr_sync (
    input  logic         clk_in,     // Source domain
    input  logic         clk_out,    // Destination domain
    input  logic         rst_n,
    input  tx_pkg::ptr_t ptr_in,     // Binary, source domain
    output tx_pkg::ptr_t ptr_out     // Binary, destination domain
);

    tx_pkg::ptr_t gray_src;          // Launch register
    tx_pkg::ptr_t meta_q;            // First stage, may go metastable
    tx_pkg::ptr_t sync_q;            // Second stage

    // Gray back to binary, MSB first
    function automatic tx_pkg::ptr_t gray2bin(tx_pkg::ptr_t g);
        tx_pkg::ptr_t b;
        b[tx_pkg::IBUF_AW] = g[tx_pkg::IBUF_AW];
        for (int i = tx_pkg::IBUF_AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    //----------------------------------------
    // Source side
    //----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            gray_src <= '0;
        end else begin
            gray_src <= ptr_in ^ (ptr_in >> 1);   // Binary to Gray
        end
    end

    //----------------------------------------
    // Destination side
    //----------------------------------------
    always_ff @(posedge clk_out or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gray_src;
            sync_q <= meta_q;
        end
    end

    assign ptr_out = gray2bin(sync_q);

endmodule

//--- hw/ibuf_writer.sv
//----------------------------------------
// Host side frame writer on pcie_clk
// Header slot, data store, length header
// Producer commit and buf_ready
//----------------------------------------
`timescale 1ns/1ns

module ibuf_writer (
    input  logic           pcie_clk,
    input  logic           rst_n,
    // Host port
    input  logic           wr_valid,
    input  logic           wr_sof,
    input  logic           wr_eof,
    input  tx_pkg::rem_t   wr_rem,      // Sampled with wr_eof
    input  tx_pkg::qword_t wr_data,
    output logic           buf_ready,
    // Pointers
    input  tx_pkg::ptr_t   cons_ptr,    // Synchronized from mac_clk
    output tx_pkg::ptr_t   prod_ptr,    // End of committed frames
    // Buffer write port
    output logic           ram_we,
    output tx_pkg::addr_t  ram_addr,
    output tx_pkg::qword_t ram_wdata
);

    tx_pkg::ptr_t  wr_ptr;              // Next data word
    tx_pkg::addr_t hdr_addr;            // Header slot of this frame
    tx_pkg::flen_t byte_cnt;            // Bytes stored so far
    tx_pkg::flen_t byte_inc;
    tx_pkg::ptr_t  used_qw;             // Occupied words
    logic          in_frame;
    logic          hdr_pend;            // Header write this cycle

    assign byte_inc = wr_eof ? tx_pkg::flen_t'(wr_rem) : tx_pkg::flen_t'(8);
    assign used_qw  = prod_ptr - cons_ptr;    // Wrap bit keeps full apart from empty

    // Room for a largest frame, and nothing half written
    assign buf_ready = !in_frame && !hdr_pend &&
        (used_qw <= tx_pkg::ptr_t'(2**tx_pkg::IBUF_AW - tx_pkg::FRAME_SLOT_QW));

    //----------------------------------------
    // Buffer port
    //----------------------------------------
    assign ram_we    = wr_valid | hdr_pend;
    assign ram_addr  = hdr_pend ? hdr_addr :
                       wr_sof   ? prod_ptr[tx_pkg::IBUF_AW-1:0] + tx_pkg::addr_t'(1) :
                                  wr_ptr[tx_pkg::IBUF_AW-1:0];
    assign ram_wdata = hdr_pend ? tx_pkg::qword_t'(byte_cnt) : wr_data;   // Length in low 16

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
            hdr_pend <= 1'b0;
            wr_ptr   <= '0;
            prod_ptr <= '0;
        end else begin
            hdr_pend <= wr_valid && wr_eof;
            if (wr_valid) begin
                in_frame <= !wr_eof;
                wr_ptr   <= (wr_sof ? prod_ptr + tx_pkg::ptr_t'(1) : wr_ptr)
                            + tx_pkg::ptr_t'(1);
            end
            if (hdr_pend) begin
                prod_ptr <= wr_ptr;             // Commit, two cycles after eof
            end
        end
    end

    // Frame length and header slot
    always_ff @(posedge pcie_clk) begin
        if (wr_valid) begin
            byte_cnt <= (wr_sof ? tx_pkg::flen_t'(0) : byte_cnt) + byte_inc;
            if (wr_sof) begin
                hdr_addr <= prod_ptr[tx_pkg::IBUF_AW-1:0];
            end
        end
    end

    //----------------------------------------
    // Host protocol checks
    //----------------------------------------
    a_sof_ready: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        wr_valid && wr_sof |-> buf_ready);
    a_valid_in_frame: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        wr_valid && !wr_sof |-> in_frame);
    a_rem_range: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        wr_valid && wr_eof |-> wr_rem inside {[1:8]});
    a_frame_len: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        wr_valid && wr_eof |=>
        byte_cnt inside {[tx_pkg::MIN_FRAME_BYTES:tx_pkg::MAX_FRAME_BYTES]});

endmodule

//--- hw/mac_tx_fsm.sv
//----------------------------------------
// Frame sender on mac_clk
// Header read, MAC request, gapless stream
// Consumer commit
//----------------------------------------
`timescale 1ns/1ns

module mac_tx_fsm (
    input  logic           mac_clk,
    input  logic           rst_n,
    input  tx_pkg::ptr_t   prod_ptr,        // Synchronized from pcie_clk
    output tx_pkg::ptr_t   cons_ptr,        // Committed read position
    output tx_pkg::addr_t  rd_addr,
    input  tx_pkg::qword_t rd_data,         // One cycle after rd_addr
    output logic           mac_tx_start,
    input  logic           mac_tx_ack,
    output tx_pkg::qword_t mac_tx_data,
    output tx_pkg::bmask_t mac_tx_data_valid
);

    tx_pkg::mac_state_e state;
    tx_pkg::ptr_t       rd_ptr;             // One word ahead of the MAC
    tx_pkg::addr_t      qw_left;            // Words still to send
    tx_pkg::bmask_t     last_mask;          // Bytes of the final word
    tx_pkg::flen_t      hdr_len;

    assign hdr_len = rd_data[15:0];
    assign rd_addr = rd_ptr[tx_pkg::IBUF_AW-1:0];

    //----------------------------------------
    // MAC port
    //----------------------------------------
    assign mac_tx_start      = (state == tx_pkg::ST_START);
    assign mac_tx_data       = rd_data;     // Straight from the read register
    assign mac_tx_data_valid = (state != tx_pkg::ST_STREAM) ? '0 :
                               (qw_left == tx_pkg::addr_t'(1)) ? last_mask : '1;

    always_ff @(posedge mac_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= tx_pkg::ST_IDLE;
            rd_ptr    <= '0;
            cons_ptr  <= '0;
            qw_left   <= '0;
            last_mask <= '0;
        end else begin
            case (state)
                tx_pkg::ST_IDLE: begin
                    if (prod_ptr != cons_ptr) begin         // Header address already out
                        rd_ptr <= rd_ptr + tx_pkg::ptr_t'(1);
                        state  <= tx_pkg::ST_HEADER;
                    end
                end
                tx_pkg::ST_HEADER: begin
                    qw_left   <= tx_pkg::addr_t'((hdr_len + tx_pkg::flen_t'(7)) >> 3);
                    last_mask <= (hdr_len[2:0] == 3'd0) ? '1 :
                                 ~(tx_pkg::bmask_t'('1) << hdr_len[2:0]);
                    state     <= tx_pkg::ST_START;
                end
                tx_pkg::ST_START: begin
                    if (mac_tx_ack) begin                   // First word read meanwhile
                        rd_ptr <= rd_ptr + tx_pkg::ptr_t'(1);
                        state  <= tx_pkg::ST_STREAM;
                    end
                end
                tx_pkg::ST_STREAM: begin
                    qw_left <= qw_left - tx_pkg::addr_t'(1);
                    if (qw_left == tx_pkg::addr_t'(1)) begin
                        state <= tx_pkg::ST_COMMIT;         // rd_ptr on next header
                    end else begin
                        rd_ptr <= rd_ptr + tx_pkg::ptr_t'(1);
                    end
                end
                tx_pkg::ST_COMMIT: begin
                    cons_ptr <= rd_ptr;
                    state    <= tx_pkg::ST_IDLE;
                end
                default: state <= tx_pkg::ST_IDLE;
            endcase
        end
    end

    //----------------------------------------
    // Sender checks
    //----------------------------------------
    // Header read back intact across the clock crossing
    a_header_len: assert property (@(posedge mac_clk) disable iff (!rst_n)
        (state == tx_pkg::ST_HEADER) |->
        hdr_len inside {[tx_pkg::MIN_FRAME_BYTES:tx_pkg::MAX_FRAME_BYTES]});
    a_valid_after_ack: assert property (@(posedge mac_clk) disable iff (!rst_n)
        $rose(|mac_tx_data_valid) |-> $past(mac_tx_start && mac_tx_ack));

endmodule

//--- hw/irq_timer.sv
//----------------------------------------
// Send interrupt with hold-off on pcie_clk
//----------------------------------------
`timescale 1ns/1ns

module irq_timer (
    input  logic         pcie_clk,
    input  logic         rst_n,
    input  tx_pkg::ptr_t prod_ptr,     // Committed by the writer
    input  tx_pkg::ptr_t cons_ptr,     // Synchronized from mac_clk
    output logic         send_irq      // One cycle pulse
);

    tx_pkg::hold_t holdoff_cnt;        // Cycles since last irq, saturating
    tx_pkg::ptr_t  irq_cons;           // Consumer pointer at last irq
    logic          drained;
    logic          progress;
    logic          holdoff_done;
    logic          fire;

    assign drained      = (cons_ptr == prod_ptr);    // MAC caught up
    assign progress     = (cons_ptr != irq_cons);    // Something sent since
    assign holdoff_done = (holdoff_cnt == tx_pkg::hold_t'(tx_pkg::IRQ_HOLDOFF));
    assign fire         = drained && progress && holdoff_done;

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            holdoff_cnt <= tx_pkg::hold_t'(tx_pkg::IRQ_HOLDOFF);   // No irq yet
            irq_cons    <= '0;
            send_irq    <= 1'b0;
        end else begin
            send_irq <= fire;
            if (fire) begin
                holdoff_cnt <= '0;
                irq_cons    <= cons_ptr;
            end else if (!holdoff_done) begin
                holdoff_cnt <= holdoff_cnt + tx_pkg::hold_t'(1);
            end
        end
    end

endmodule

//--- hw/tx_path.sv
//----------------------------------------
// Transmit path top level
// Writer, buffer, pointer syncs, sender, irq
//----------------------------------------
`timescale 1ns/1ns

module tx_path (
    input  logic           pcie_clk,
    input  logic           mac_clk,
    input  logic           rst_n,
    // Host write port, pcie_clk
    input  logic           wr_valid,
    input  logic           wr_sof,
    input  logic           wr_eof,
    input  tx_pkg::rem_t   wr_rem,
    input  tx_pkg::qword_t wr_data,
    output logic           buf_ready,
    // 10G MAC transmit, mac_clk
    output logic           mac_tx_start,
    input  logic           mac_tx_ack,
    output tx_pkg::qword_t mac_tx_data,
    output tx_pkg::bmask_t mac_tx_data_valid,
    // Host interrupt, pcie_clk
    output logic           send_irq
);

    tx_pkg::ptr_t   prod_ptr;          // pcie_clk
    tx_pkg::ptr_t   prod_ptr_sync;     // mac_clk
    tx_pkg::ptr_t   cons_ptr;          // mac_clk
    tx_pkg::ptr_t   cons_ptr_sync;     // pcie_clk
    logic           ram_we;
    tx_pkg::addr_t  ram_addr;
    tx_pkg::qword_t ram_wdata;
    tx_pkg::addr_t  rd_addr;
    tx_pkg::qword_t rd_data;

    //----------------------------------------
    // pcie_clk side
    //----------------------------------------
    ibuf_writer writer_i (
        .pcie_clk  (pcie_clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_sof    (wr_sof),
        .wr_eof    (wr_eof),
        .wr_rem    (wr_rem),
        .wr_data   (wr_data),
        .buf_ready (buf_ready),
        .cons_ptr  (cons_ptr_sync),
        .prod_ptr  (prod_ptr),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    irq_timer irq_i (
        .pcie_clk (pcie_clk),
        .rst_n    (rst_n),
        .prod_ptr (prod_ptr),
        .cons_ptr (cons_ptr_sync),
        .send_irq (send_irq)
    );

    tx_ibuf ibuf_i (
        .pcie_clk (pcie_clk),
        .wr_en    (ram_we),
        .wr_addr  (ram_addr),
        .wr_data  (ram_wdata),
        .mac_clk  (mac_clk),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    //----------------------------------------
    // Clock crossings
    //----------------------------------------
    ptr_sync prod_sync_i (
        .clk_in  (pcie_clk),
        .clk_out (mac_clk),
        .rst_n   (rst_n),
        .ptr_in  (prod_ptr),
        .ptr_out (prod_ptr_sync)
    );

    ptr_sync cons_sync_i (
        .clk_in  (mac_clk),
        .clk_out (pcie_clk),
        .rst_n   (rst_n),
        .ptr_in  (cons_ptr),
        .ptr_out (cons_ptr_sync)
    );

    // mac_clk side
    mac_tx_fsm sender_i (
        .mac_clk           (mac_clk),
        .rst_n             (rst_n),
        .prod_ptr          (prod_ptr_sync),
        .cons_ptr          (cons_ptr),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .mac_tx_start      (mac_tx_start),
        .mac_tx_ack        (mac_tx_ack),
        .mac_tx_data       (mac_tx_data),
        .mac_tx_data_valid (mac_tx_data_valid)
    );

endmodule

//--- test/tx_path_tb.sv
//----------------------------------------
// Transmit path testbench
// Clocks, reset, random frames, MAC model
// Reference function, compare process
//----------------------------------------
`timescale 1ns/1ns

module tx_path_tb;

    localparam int NUM_BURSTS     = 4;
    localparam int BURST_FRAMES   = 30;
    localparam int SLOW_BURST     = 1;            // MAC holds ack 200 cycles here
    localparam int TIMEOUT_CYCLES = 200 * 400;    // 200 frames, 400 cycles each

    logic           pcie_clk = 1'b0;
    logic           mac_clk  = 1'b0;
    logic           rst_n;
    logic           wr_valid, wr_sof, wr_eof;
    tx_pkg::rem_t   wr_rem;
    tx_pkg::qword_t wr_data;
    logic           buf_ready;
    logic           mac_tx_start;
    logic           mac_tx_ack = 1'b0;
    tx_pkg::qword_t mac_tx_data;
    tx_pkg::bmask_t mac_tx_data_valid;
    logic           send_irq;

    int             exp_len[$];                   // Committed frames, in order
    tx_pkg::qword_t exp_data[$];                  // Their words, back to back
    int             host_errors = 0, mac_errors = 0, irq_errors = 0;
    int             frames_pushed = 0, frames_done = 0, frames_rx = 0, acks_sent = 0;
    int             cycle = 0, irq_count = 0, last_irq = 0, qw_left = 0;
    tx_pkg::bmask_t cur_mask = '0;
    bit             stall_mac = 1'b0, full_seen = 1'b0;

    tx_path dut_i (.*);

    always #5 mac_clk = ~mac_clk;
    always #(($time == 0) ? 8 : 5) pcie_clk = ~pcie_clk;   // 3 ns behind mac_clk

    // Expected word count and last byte mask of a frame
    function automatic void frame_ref(input int len, output int nqw,
                                      output tx_pkg::bmask_t mask);
        nqw  = (len + 7) / 8;
        mask = (len % 8 == 0) ? 8'hff : tx_pkg::bmask_t'((1 << (len % 8)) - 1);
    endfunction

    task automatic report_value(inout int cnt, input string msg);
        cnt++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    task automatic report_event(inout int cnt, input string msg);
        cnt++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    //----------------------------------------
    // Host side
    //----------------------------------------
    task automatic send_frame(input int len);
        tx_pkg::qword_t words[$];
        tx_pkg::qword_t w;
        tx_pkg::bmask_t unused_mask;
        int nqw;
        int waited;
        frame_ref(len, nqw, unused_mask);
        waited = 0;
        while (!buf_ready) begin                  // Room for a whole frame
            @(negedge pcie_clk);
            waited++;
        end
        if (stall_mac && waited > 4) full_seen = 1'b1;
        for (int i = 0; i < nqw; i++) begin
            w = {$urandom, $urandom};
            words.push_back(w);
            wr_valid = 1'b1;
            wr_sof   = (i == 0);
            wr_eof   = (i == nqw - 1);
            wr_rem   = tx_pkg::rem_t'(len - 8 * (nqw - 1));
            wr_data  = w;
            @(negedge pcie_clk);
            wr_valid = 1'b0;
            wr_sof   = 1'b0;
            wr_eof   = 1'b0;
            if (i < nqw - 1 && $urandom_range(0, 9) == 0) @(negedge pcie_clk);  // Gap
        end
        repeat (2) @(negedge pcie_clk);           // Producer pointer committed by now
        exp_len.push_back(len);
        foreach (words[k]) exp_data.push_back(words[k]);
        frames_pushed++;
    endtask

    task automatic drain_burst(input int burst);
        int base;
        while (frames_done != frames_pushed) @(negedge pcie_clk);
        base = irq_count;
        repeat (tx_pkg::IRQ_HOLDOFF + 32) begin
            if (irq_count == base) @(negedge pcie_clk);
        end
        if (irq_count == base)
            report_event(host_errors, $sformatf("no send_irq after burst %0d drained", burst));
        if (!buf_ready)
            report_event(host_errors, $sformatf("buf_ready low after burst %0d drained", burst));
    endtask

    //----------------------------------------
    // Cycle count, timeout, irq monitor
    //----------------------------------------
    always @(posedge pcie_clk) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d frames received",
                     cycle, frames_done, frames_pushed);
            $display("Errors host %0d mac %0d irq %0d",
                     host_errors, mac_errors, irq_errors);
            $display("Test failed");
            $finish;
        end else if (rst_n && send_irq) begin
            if (irq_count > 0 && cycle - last_irq < tx_pkg::IRQ_HOLDOFF)
                report_event(irq_errors, $sformatf("send_irq only %0d cycles after the last",
                                                   cycle - last_irq));
            if (frames_done != frames_pushed)
                report_event(irq_errors, "send_irq while frames are still queued");
            irq_count++;
            last_irq = cycle;
        end
    end

    // MAC model, ack after a random wait
    always begin
        @(negedge mac_clk);
        mac_tx_ack = 1'b0;
        if (rst_n && mac_tx_start) begin
            repeat (stall_mac ? 200 : $urandom_range(0, 7)) @(negedge mac_clk);
            mac_tx_ack = 1'b1;
            acks_sent++;
        end
    end

    //----------------------------------------
    // Compare process on the MAC port
    //----------------------------------------
    always @(negedge mac_clk) begin
        tx_pkg::qword_t exp_w;
        tx_pkg::bmask_t exp_m;
        int len;
        if (rst_n) begin
            if (qw_left == 0 && mac_tx_data_valid != '0) begin      // First word
                if (exp_len.size() == 0) begin
                    report_event(mac_errors, "MAC data with no frame queued");
                end else begin
                    len = exp_len.pop_front();
                    frame_ref(len, qw_left, cur_mask);
                    if (acks_sent != frames_rx + 1)
                        report_event(mac_errors, "data valid before mac_tx_ack");
                    frames_rx++;
                end
            end
            if (qw_left > 0) begin
                if (mac_tx_start)
                    report_event(mac_errors, "mac_tx_start high during a stream");
                if (mac_tx_data_valid == '0) begin
                    report_event(mac_errors, $sformatf("gap in frame %0d", frames_rx));
                end else begin
                    exp_w = exp_data.pop_front();
                    exp_m = (qw_left == 1) ? cur_mask : 8'hff;
                    if (mac_tx_data !== exp_w)
                        report_value(mac_errors, $sformatf("frame %0d data %h, expected %h",
                                                           frames_rx, mac_tx_data, exp_w));
                    if (mac_tx_data_valid !== exp_m)
                        report_value(mac_errors, $sformatf("frame %0d mask %h, expected %h",
                                                           frames_rx, mac_tx_data_valid, exp_m));
                    qw_left--;
                    if (qw_left == 0) frames_done++;
                end
            end
        end
    end

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        int len;
        void'($urandom(32'h4011_764c));
        rst_n    = 1'b0;
        wr_valid = 1'b0;
        wr_sof   = 1'b0;
        wr_eof   = 1'b0;
        wr_rem   = '0;
        wr_data  = '0;
        repeat (16) @(posedge pcie_clk);
        @(negedge pcie_clk);
        rst_n = 1'b1;
        if (mac_tx_start || mac_tx_data_valid != '0 || send_irq || !buf_ready)
            report_event(host_errors, "outputs not at their reset values");
        for (int b = 0; b < NUM_BURSTS; b++) begin
            stall_mac = (b == SLOW_BURST);
            full_seen = 1'b0;
            for (int f = 0; f < BURST_FRAMES; f++) begin
                len = tx_pkg::MIN_FRAME_BYTES + int'($urandom_range(0,
                      tx_pkg::MAX_FRAME_BYTES - tx_pkg::MIN_FRAME_BYTES));
                if (f % 5 == 0) len = (len < 64) ? 64 : (len & ~7);   // Full last word
                send_frame(len);
            end
            if (stall_mac && !full_seen)
                report_event(host_errors, "buf_ready never fell while the MAC stalled");
            stall_mac = 1'b0;
            drain_burst(b);
        end
        $display("Frames %0d sent, %0d received, irqs %0d, errors host %0d mac %0d irq %0d",
                 frames_pushed, frames_done, irq_count, host_errors, mac_errors, irq_errors);
        if (host_errors + mac_errors + irq_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/tx_pkg.sv
hw/tx_ibuf.sv
hw/ptr_sync.sv
hw/ibuf_writer.sv
hw/mac_tx_fsm.sv
hw/irq_timer.sv
hw/tx_path.sv
test/tx_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the transmit path testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tx_path_tb -o tx_path_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tx_path_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
